/* msx_pkg.sv */
package msx_pkg;

   // CPU bus cycle as seen by every block on the system bus
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  data;
      logic        rd;
      logic        wr;
      logic        iorq;
      logic        mreq;
      logic        m1;
   } cpu_bus_t;

   // Kind of memory behind one 16 KB page of a slot
   typedef enum logic [1:0] {
      BLK_NONE = 2'd0,
      BLK_RAM  = 2'd1,
      BLK_ROM  = 2'd2
   } block_kind_t;

   // One slot layout entry, base counts 16 KB blocks in external memory
   typedef struct packed {
      block_kind_t kind;
      logic [7:0]  base;
   } block_t;

   // Indexed by slot, subslot and page, two bits each
   localparam int LAYOUT_ENTRIES = 64;

   // Request towards the external memory
   typedef struct packed {
      logic [21:0] addr;
      logic [7:0]  din;
      logic        rnw;
      logic        ce;
   } mem_req_t;

   // Upper five bits of the I/O port address
   localparam logic [4:0] PORT_VDP = 5'b10011;
   localparam logic [4:0] PORT_PSG = 5'b10100;
   localparam logic [4:0] PORT_PPI = 5'b10101;

   // Secondary slot register location
   localparam logic [15:0] SUBSLOT_ADDR = 16'hFFFF;
   localparam logic [1:0]  SUBSLOT_SLOT = 2'd3;

endpackage

/* msx_wait_gen.sv */
`timescale 1ns/1ns

module msx_wait_gen (
   input  logic              clock_bus,
   input  logic              reset,
   input  logic              ce_cpu,
   input  msx_pkg::cpu_bus_t cpu,
   output logic              wait_n
);

   // Set again once M1 is seen low, cleared when a wait state is issued
   logic m1_armed;

   always_ff @(posedge clock_bus or posedge reset) begin
      if (reset) begin
         wait_n   <= 1'b1;
         m1_armed <= 1'b1;
      end else if (ce_cpu) begin
         if (!wait_n) begin
            // Wait state lasts a single CPU tick
            wait_n <= 1'b1;
         end else if (m1_armed && cpu.m1 && cpu.mreq) begin
            wait_n   <= 1'b0;
            m1_armed <= 1'b0;
         end
         if (!cpu.m1) begin
            m1_armed <= 1'b1;
         end
      end
   end

   // The CPU may never be stalled past the second tick after the wait started
   a_wait_short : assert property (@(posedge clock_bus) disable iff (reset)
      $fell(wait_n) |-> ##1 ce_cpu [->2] ##0 wait_n)
      else $error("wait_n held low for more than two ce_cpu ticks");

endmodule

/* msx_io_decode.sv */
`timescale 1ns/1ns

module msx_io_decode (
   input  msx_pkg::cpu_bus_t cpu,
   input  logic [7:0]        ppi_data,
   input  logic [7:0]        psg_data,
   input  logic [7:0]        vdp_data,
   input  logic [7:0]        sub_data,
   input  logic [7:0]        slot_data,
   input  logic              sub_rq,
   input  logic              mem_ce,
   output logic              ppi_sel,
   output logic              psg_sel,
   output logic              vdp_sel,
   output logic [7:0]        d_to_cpu
);

   import msx_pkg::*;

   logic io_cycle;

   // Interrupt acknowledge also raises iorq, but together with m1
   assign io_cycle = cpu.iorq && !cpu.m1;

   assign vdp_sel = io_cycle && (cpu.addr[7:3] == PORT_VDP);
   assign psg_sel = io_cycle && (cpu.addr[7:3] == PORT_PSG);
   assign ppi_sel = io_cycle && (cpu.addr[7:3] == PORT_PPI);

   // Read data back to the CPU, fixed priority
   always_comb begin
      if (!cpu.rd) begin
         d_to_cpu = 8'hFF;
      end else if (vdp_sel) begin
         d_to_cpu = vdp_data;
      end else if (psg_sel) begin
         d_to_cpu = psg_data;
      end else if (ppi_sel) begin
         d_to_cpu = ppi_data;
      end else if (sub_rq) begin
         d_to_cpu = sub_data;
      end else if (mem_ce && cpu.mreq) begin
         d_to_cpu = slot_data;
      end else begin
         d_to_cpu = 8'hFF;   // open bus
      end
   end

   // Port selects and the subslot request never compete for the data bus
   always_comb begin
      a_one_source : assert final ($onehot0({vdp_sel, psg_sel, ppi_sel, sub_rq}))
         else $error("more than one read source selected");
   end

endmodule

/* msx_ppi.sv */
`timescale 1ns/1ns

module msx_ppi (
   input  logic              clock_bus,
   input  logic              reset,
   input  msx_pkg::cpu_bus_t cpu,
   input  logic              sel,
   input  logic [7:0]        kbd_data,
   output logic [7:0]        ppi_data,
   output logic [7:0]        slot_reg,
   output logic              map_valid,
   output logic              keybeep,
   output logic              cas_motor,
   output logic [3:0]        kbd_row
);

   logic [7:0] port_c;
   logic       access;
   logic       write;

   assign access = sel && (cpu.rd || cpu.wr);
   assign write  = sel && cpu.wr;

   // Port A is the primary slot register, two bits per page
   always_ff @(posedge clock_bus or posedge reset) begin
      if (reset) begin
         slot_reg  <= 8'h00;
         port_c    <= 8'h00;
         map_valid <= 1'b0;
      end else begin
         // Slot map stays on slot 0 until the BIOS first touches the PPI
         if (access) begin
            map_valid <= 1'b1;
         end
         if (write) begin
            case (cpu.addr[1:0])
               2'd0: slot_reg <= cpu.data;
               2'd2: port_c <= cpu.data;
               2'd3: begin
                  // Bit set/reset only, mode words are not supported
                  if (!cpu.data[7]) begin
                     port_c[cpu.data[3:1]] <= cpu.data[0];
                  end
               end
               default: ;
            endcase
         end
      end
   end

   // Mode 0 readback, port B is the keyboard column input
   always_comb begin
      case (cpu.addr[1:0])
         2'd0:    ppi_data = slot_reg;
         2'd1:    ppi_data = kbd_data;
         2'd2:    ppi_data = port_c;
         default: ppi_data = 8'hFF;
      endcase
   end

   assign keybeep   = port_c[7];
   assign cas_motor = port_c[4];
   assign kbd_row   = port_c[3:0];

endmodule

/* msx_subslot.sv */
`timescale 1ns/1ns

module msx_subslot (
   input  logic              clock_bus,
   input  logic              reset,
   input  msx_pkg::cpu_bus_t cpu,
   input  logic              expander_en,
   input  logic [1:0]        primary_slot,
   output logic [1:0]        subslot_sel,
   output logic              sub_rq,
   output logic [7:0]        sub_data
);

   import msx_pkg::*;

   logic [7:0] sub_reg;
   logic       expanded;
   logic       hit;

   assign expanded = expander_en && (primary_slot == SUBSLOT_SLOT);
   assign hit      = expanded && cpu.mreq && (cpu.addr == SUBSLOT_ADDR);

   always_ff @(posedge clock_bus or posedge reset) begin
      if (reset) begin
         sub_reg <= 8'h00;
      end else if (hit && cpu.wr) begin
         sub_reg <= cpu.data;
      end
   end

   // Reads return the complement, which is how software detects an expander
   assign sub_rq   = hit && cpu.rd;
   assign sub_data = ~sub_reg;

   // Subslot for the page being addressed
   always_comb begin
      if (!expanded) begin
         subslot_sel = 2'b00;
      end else begin
         case (cpu.addr[15:14])
            2'd0:    subslot_sel = sub_reg[1:0];
            2'd1:    subslot_sel = sub_reg[3:2];
            2'd2:    subslot_sel = sub_reg[5:4];
            default: subslot_sel = sub_reg[7:6];
         endcase
      end
   end

endmodule

/* msx_slot_map.sv */
`timescale 1ns/1ns

module msx_slot_map (
   input  msx_pkg::cpu_bus_t cpu,
   input  logic [7:0]        slot_reg,
   input  logic              map_valid,
   input  logic [1:0]        subslot_sel,
   input  logic              expander_en,
   input  msx_pkg::block_t   slot_layout [msx_pkg::LAYOUT_ENTRIES],
   input  logic [7:0]        ram_dout,
   output logic [1:0]        primary_slot,
   output msx_pkg::mem_req_t mem,
   output logic [7:0]        slot_data
);

   import msx_pkg::*;

   logic [1:0] page;
   block_t     ent;
   logic       sub_hit;

   assign page = cpu.addr[15:14];

   always_comb begin
      primary_slot = map_valid ? slot_reg[2*page +: 2] : 2'd0;
      ent          = slot_layout[{primary_slot, subslot_sel, page}];
      sub_hit      = expander_en && (primary_slot == SUBSLOT_SLOT) &&
                     cpu.mreq && (cpu.addr == SUBSLOT_ADDR);
      mem.addr     = {ent.base, cpu.addr[13:0]};
      mem.din      = cpu.data;
      mem.rnw      = !cpu.wr;
      mem.ce       = cpu.mreq && !sub_hit &&
                     ((ent.kind == BLK_RAM && (cpu.rd || cpu.wr)) ||
                      (ent.kind == BLK_ROM && cpu.rd));
   end

   assign slot_data = ram_dout;

endmodule

/* msx_audio_mix.sv */
`timescale 1ns/1ns

module msx_audio_mix (
   input  logic               clock_bus,
   input  logic               reset,
   input  logic [9:0]         psg_level,
   input  logic               keybeep,
   input  logic               cas_in,
   input  logic               cas_motor,
   input  logic signed [15:0] dev_sound,
   output logic signed [15:0] audio
);

   logic [10:0] psg_sum;
   logic [16:0] fm;
   logic [16:0] mix;
   logic [15:0] sat;

   // Key click and cassette monitor ride on top of the PSG level
   assign psg_sum = {1'b0, psg_level}
                  + {5'b0, keybeep, 5'b0}
                  + {6'b0, cas_in && !cas_motor, 4'b0};

   assign fm  = {2'b00, psg_sum, 4'b0000};
   assign mix = {dev_sound[15], dev_sound} + fm;

   // Clip when the top three bits disagree
   always_comb begin
      case (mix[16:14])
         3'b000, 3'b111: sat = {mix[16], mix[13:0], 1'b0};
         3'b001, 3'b010, 3'b011: sat = 16'h7FFF;
         default: sat = 16'h8000;
      endcase
   end

   always_ff @(posedge clock_bus or posedge reset) begin
      if (reset) begin
         audio <= '0;
      end else begin
         audio <= sat;
      end
   end

endmodule

/* msx_core.sv */
`timescale 1ns/1ns

module msx_core (
   input  logic               clock_bus,
   input  logic               reset,
   input  logic               ce_cpu,
   input  msx_pkg::cpu_bus_t  cpu,
   input  logic [7:0]         kbd_data,
   input  logic [7:0]         psg_data,
   input  logic [7:0]         vdp_data,
   input  logic [7:0]         ram_dout,
   input  logic [9:0]         psg_level,
   input  logic signed [15:0] dev_sound,
   input  logic               cas_in,
   input  logic               expander_en,
   input  msx_pkg::block_t    slot_layout [msx_pkg::LAYOUT_ENTRIES],
   output logic [7:0]         d_to_cpu,
   output logic               wait_n,
   output msx_pkg::mem_req_t  mem,
   output logic [3:0]         kbd_row,
   output logic               cas_motor,
   output logic signed [15:0] audio
);

   logic       ppi_sel;
   logic [7:0] ppi_data;
   logic [7:0] slot_reg;
   logic       map_valid;
   logic       keybeep;
   logic [1:0] primary_slot;
   logic [1:0] subslot_sel;
   logic       sub_rq;
   logic [7:0] sub_data;
   logic [7:0] slot_data;

   msx_wait_gen u_wait (
      .clock_bus (clock_bus),
      .reset     (reset),
      .ce_cpu    (ce_cpu),
      .cpu       (cpu),
      .wait_n    (wait_n)
   );

   // PSG and VDP live outside the core, only their read data comes back
   msx_io_decode u_decode (
      .cpu       (cpu),
      .ppi_data  (ppi_data),
      .psg_data  (psg_data),
      .vdp_data  (vdp_data),
      .sub_data  (sub_data),
      .slot_data (slot_data),
      .sub_rq    (sub_rq),
      .mem_ce    (mem.ce),
      .ppi_sel   (ppi_sel),
      .psg_sel   (),
      .vdp_sel   (),
      .d_to_cpu  (d_to_cpu)
   );

   msx_ppi u_ppi (
      .clock_bus (clock_bus),
      .reset     (reset),
      .cpu       (cpu),
      .sel       (ppi_sel),
      .kbd_data  (kbd_data),
      .ppi_data  (ppi_data),
      .slot_reg  (slot_reg),
      .map_valid (map_valid),
      .keybeep   (keybeep),
      .cas_motor (cas_motor),
      .kbd_row   (kbd_row)
   );

   msx_subslot u_subslot (
      .clock_bus    (clock_bus),
      .reset        (reset),
      .cpu          (cpu),
      .expander_en  (expander_en),
      .primary_slot (primary_slot),
      .subslot_sel  (subslot_sel),
      .sub_rq       (sub_rq),
      .sub_data     (sub_data)
   );

   msx_slot_map u_slot_map (
      .cpu          (cpu),
      .slot_reg     (slot_reg),
      .map_valid    (map_valid),
      .subslot_sel  (subslot_sel),
      .expander_en  (expander_en),
      .slot_layout  (slot_layout),
      .ram_dout     (ram_dout),
      .primary_slot (primary_slot),
      .mem          (mem),
      .slot_data    (slot_data)
   );

   msx_audio_mix u_audio (
      .clock_bus (clock_bus),
      .reset     (reset),
      .psg_level (psg_level),
      .keybeep   (keybeep),
      .cas_in    (cas_in),
      .cas_motor (cas_motor),
      .dev_sound (dev_sound),
      .audio     (audio)
   );

endmodule

/* msx_checker.sv */
`timescale 1ns/1ns

module msx_checker (
   input  logic               clock_bus,
   input  logic               reset,
   input  logic               ce_cpu,
   input  msx_pkg::cpu_bus_t  cpu,
   input  logic               expander_en,
   input  msx_pkg::block_t    slot_layout [msx_pkg::LAYOUT_ENTRIES],
   input  logic [7:0]         ram_dout,
   input  logic [9:0]         psg_level,
   input  logic signed [15:0] dev_sound,
   input  logic               cas_in,
   input  logic               chk_en,
   input  logic [7:0]         chk_exp,
   input  logic [7:0]         d_to_cpu,
   input  logic               wait_n,
   input  msx_pkg::mem_req_t  mem,
   input  logic [3:0]         kbd_row,
   input  logic               cas_motor,
   input  logic signed [15:0] audio,
   output int                 errors,
   output int                 checks
);

   import msx_pkg::*;

   logic [7:0]         slot_m;
   logic [7:0]         port_c_m;
   logic [7:0]         sub_m;
   logic               valid_m;
   logic               wait_m;
   logic               armed_m;
   logic signed [15:0] audio_m;
   logic [1:0]         pslot;
   logic [1:0]         sslot;
   logic [1:0]         page;
   logic               expanded;
   logic               hit;
   logic               exp_ce;
   logic [7:0]         exp_d;
   block_t             ent;

   // In range the mixer output is twice the 17-bit sum
   function automatic logic [15:0] mix_ref(input logic [9:0] lvl, input logic beep,
                                           input logic cin, input logic motor,
                                           input logic signed [15:0] dev);
      int s;
      s = lvl + (beep ? 32 : 0) + ((cin && !motor) ? 16 : 0);
      s = s * 16 + dev;
      if (s > 16383) return 16'h7FFF;
      if (s < -16384) return 16'h8000;
      return 16'(s * 2);
   endfunction

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   // Expected memory request for the current bus cycle
   always_comb begin
      page     = cpu.addr[15:14];
      pslot    = valid_m ? slot_m[2*page +: 2] : 2'd0;
      expanded = expander_en && (pslot == 2'd3);
      sslot    = expanded ? sub_m[2*page +: 2] : 2'd0;
      hit      = expanded && cpu.mreq && (cpu.addr == 16'hFFFF);
      ent      = slot_layout[{pslot, sslot, page}];
      exp_ce   = cpu.mreq && !hit &&
                 ((ent.kind == BLK_RAM && (cpu.rd || cpu.wr)) ||
                  (ent.kind == BLK_ROM && cpu.rd));
      if (!cpu.rd) exp_d = 8'hFF;
      else if (chk_en) exp_d = chk_exp;
      else if (hit) exp_d = ~sub_m;
      else if (exp_ce) exp_d = ram_dout;
      else exp_d = 8'hFF;
   end

   always @(posedge clock_bus or posedge reset) begin
      if (reset) begin
         slot_m   <= 8'h00;
         port_c_m <= 8'h00;
         sub_m    <= 8'h00;
         valid_m  <= 1'b0;
         wait_m   <= 1'b1;
         armed_m  <= 1'b1;
         audio_m  <= 16'h0000;
      end else begin
         if (cpu.iorq && !cpu.m1 && cpu.addr[7:3] == 5'b10101) begin
            if (cpu.rd || cpu.wr) valid_m <= 1'b1;
            if (cpu.wr && cpu.addr[1:0] == 2'd0) slot_m <= cpu.data;
            if (cpu.wr && cpu.addr[1:0] == 2'd2) port_c_m <= cpu.data;
            if (cpu.wr && cpu.addr[1:0] == 2'd3 && !cpu.data[7])
               port_c_m[cpu.data[3:1]] <= cpu.data[0];
         end
         if (hit && cpu.wr) sub_m <= cpu.data;
         audio_m <= mix_ref(psg_level, port_c_m[7], cas_in, port_c_m[4], dev_sound);
         // One wait state per M1 cycle until M1 has been low again
         if (ce_cpu) begin
            if (!wait_m) begin
               wait_m <= 1'b1;
            end else if (armed_m && cpu.m1 && cpu.mreq) begin
               wait_m  <= 1'b0;
               armed_m <= 1'b0;
            end
            if (!cpu.m1) armed_m <= 1'b1;
         end
      end
   end

   always @(negedge clock_bus) begin
      if (!reset) begin
         compare("d_to_cpu", d_to_cpu, exp_d);
         compare("mem.ce", mem.ce, exp_ce);
         if (exp_ce) begin
            compare("mem.addr", mem.addr, {ent.base, cpu.addr[13:0]});
            compare("mem.rnw", mem.rnw, !cpu.wr);
            compare("mem.din", mem.din, cpu.data);
         end
         compare("kbd_row", kbd_row, port_c_m[3:0]);
         compare("cas_motor", cas_motor, port_c_m[4]);
         compare("audio", audio, audio_m);
         compare("wait_n", wait_n, wait_m);
      end
   end

endmodule

/* msx_tb.sv */
`timescale 1ns/1ns

module msx_tb;

   import msx_pkg::*;

   localparam int K_IOW = 0, K_IOR = 1, K_MR = 2, K_MW = 3, K_AUD = 4, K_FETCH = 5, K_EXP = 6;

   typedef struct packed {
      int          kind;
      logic [15:0] addr;
      logic [7:0]  data;
      logic [7:0]  exp;
   } op_t;

   logic clock_bus = 1'b0;
   logic reset;
   logic ce_cpu;
   cpu_bus_t cpu;
   logic [7:0] kbd_data, psg_data, vdp_data, ram_dout;
   logic [9:0] psg_level;
   logic signed [15:0] dev_sound;
   logic cas_in, expander_en, chk_en;
   logic [7:0] chk_exp;
   block_t slot_layout [LAYOUT_ENTRIES];
   logic [7:0] d_to_cpu;
   logic wait_n, cas_motor;
   mem_req_t mem;
   logic [3:0] kbd_row;
   logic signed [15:0] audio;
   int errors, checks, cycles, limit, ce_cnt;
   logic [31:0] lcg_state = 32'h6d0acdb0;
   op_t table_q[$];

   msx_core u_dut (.*);

   msx_checker u_chk (.*);

   always #4 clock_bus = ~clock_bus;

   // One CPU clock enable pulse every 6 clocks
   always @(posedge clock_bus) begin
      #1;
      ce_cnt = (ce_cnt == 5) ? 0 : ce_cnt + 1;
      ce_cpu = (ce_cnt == 0);
   end

   always @(posedge clock_bus) begin
      cycles++;
      if (cycles > limit) begin
         $display("Timeout: run did not finish within %0d clocks", limit);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic add_op(input int kind, input logic [15:0] addr, input logic [7:0] data,
                         input logic [7:0] exp);
      op_t o;
      o.kind = kind;
      o.addr = addr;
      o.data = data;
      o.exp  = exp;
      table_q.push_back(o);
   endtask

   task automatic run_op(input op_t o);
      logic [31:0] r;
      @(posedge clock_bus);
      #1;
      cpu.addr = o.addr;
      cpu.data = o.data;
      case (o.kind)
         K_IOW: {cpu.iorq, cpu.wr} = 2'b11;
         K_IOR: {cpu.iorq, cpu.rd, chk_en, chk_exp} = {3'b111, o.exp};
         K_MR: {cpu.mreq, cpu.rd} = 2'b11;
         K_MW: {cpu.mreq, cpu.wr} = 2'b11;
         K_FETCH: {cpu.mreq, cpu.rd, cpu.m1} = 3'b111;
         K_EXP: expander_en = o.data[0];
         default: begin
            r = lcg_next();
            psg_level = r[9:0];
            cas_in    = r[10];
            dev_sound = r[31:16];
            // Directed entries push the mix past either clip point
            if (o.data == 8'h01) begin
               dev_sound = 16'h7FFF;
            end else if (o.data == 8'h02) begin
               psg_level = {1'b0, r[8:0]};
               dev_sound = 16'h8000;
            end
         end
      endcase
      @(posedge clock_bus);
      // Opcode fetch holds until its wait state has come and gone
      if (o.kind == K_FETCH) begin
         while (wait_n) @(posedge clock_bus);
         while (!wait_n) @(posedge clock_bus);
      end
      #1;
      cpu    = '0;
      chk_en = 1'b0;
      if (o.kind == K_FETCH) begin
         do @(posedge clock_bus); while (!ce_cpu);
      end
   endtask

   initial begin
      cpu = '0;
      {reset, ce_cpu, cas_in, expander_en, chk_en, chk_exp} = {4'b1000, 1'b0, 8'h00};
      {kbd_data, psg_data, vdp_data, ram_dout} = 32'h3C96_A55A;
      {psg_level, dev_sound} = '0;
      {ce_cnt, cycles, limit} = {32'd0, 32'd0, 32'd100000};
      for (int i = 0; i < LAYOUT_ENTRIES; i++) begin
         slot_layout[i].kind = block_kind_t'((i + 1) % 3);
         slot_layout[i].base = 8'(i * 5 + 3);
      end
      // Slot 0 everywhere after reset
      add_op(K_MR, 16'h0000, 8'h00, 8'h00);
      add_op(K_MW, 16'h4000, 8'h11, 8'h00);
      add_op(K_MW, 16'h8000, 8'h22, 8'h00);
      add_op(K_MR, 16'hC000, 8'h00, 8'h00);
      add_op(K_FETCH, 16'h0010, 8'h00, 8'h00);
      add_op(K_IOR, 16'h00A9, 8'h00, 8'h3C);
      add_op(K_IOW, 16'h00A8, 8'hE4, 8'h00);
      add_op(K_IOR, 16'h00A8, 8'h00, 8'hE4);
      add_op(K_MR, 16'h0100, 8'h00, 8'h00);
      add_op(K_MR, 16'h4100, 8'h00, 8'h00);
      add_op(K_MR, 16'h8100, 8'h00, 8'h00);
      add_op(K_MW, 16'h8100, 8'h33, 8'h00);
      add_op(K_MR, 16'hC100, 8'h00, 8'h00);
      add_op(K_MW, 16'hC100, 8'h44, 8'h00);
      // Page 3 of expanded slot 3 moves to subslot 1
      add_op(K_EXP, 16'h0000, 8'h01, 8'h00);
      add_op(K_MW, 16'hFFFF, 8'h6C, 8'h00);
      add_op(K_MR, 16'hFFFF, 8'h00, 8'h00);
      add_op(K_MR, 16'hC200, 8'h00, 8'h00);
      add_op(K_MW, 16'hC200, 8'h55, 8'h00);
      add_op(K_EXP, 16'h0000, 8'h00, 8'h00);
      add_op(K_MR, 16'hFFFF, 8'h00, 8'h00);
      add_op(K_MW, 16'hC200, 8'h66, 8'h00);
      add_op(K_IOR, 16'h0098, 8'h00, 8'hA5);
      add_op(K_IOR, 16'h00A2, 8'h00, 8'h96);
      add_op(K_IOR, 16'h0040, 8'h00, 8'hFF);
      add_op(K_IOW, 16'h00AA, 8'h85, 8'h00);
      add_op(K_IOW, 16'h00AB, 8'h0E, 8'h00);
      add_op(K_IOW, 16'h00AB, 8'h09, 8'h00);
      add_op(K_IOW, 16'h00AB, 8'h8F, 8'h00);
      add_op(K_IOR, 16'h00AA, 8'h00, 8'h15);
      for (int i = 0; i < 6; i++) add_op(K_AUD, 16'h0000, 8'h00, 8'h00);
      add_op(K_AUD, 16'h0000, 8'h01, 8'h00);
      add_op(K_AUD, 16'h0000, 8'h02, 8'h00);
      add_op(K_IOW, 16'h00AB, 8'h08, 8'h00);
      add_op(K_IOW, 16'h00AB, 8'h0F, 8'h00);
      for (int i = 0; i < 6; i++) add_op(K_AUD, 16'h0000, 8'h00, 8'h00);
      add_op(K_FETCH, 16'h0020, 8'h00, 8'h00);
      add_op(K_FETCH, 16'h4020, 8'h00, 8'h00);
      limit = table_q.size() * 8 + 200;
      repeat (10) @(posedge clock_bus);
      #1;
      reset = 1'b0;
      foreach (table_q[i]) run_op(table_q[i]);
      repeat (4) @(posedge clock_bus);
      $display("Errors: %0d in %0d checks", errors, checks);
      if (errors == 0 && checks > 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

/* msx_core.f */
msx_pkg.sv
msx_wait_gen.sv
msx_io_decode.sv
msx_ppi.sv
msx_subslot.sv
msx_slot_map.sv
msx_audio_mix.sv
msx_core.sv
msx_checker.sv
msx_tb.sv
